//--- pit_apb_pkg.sv
//=============================
// Bus-side types of the interval timer
// APB request and response bundles plus register map
// Import into any module touching the APB port
//=============================
`default_nettype none

`include "pit_macros.svh"

package pit_apb_pkg;

    //=============================
    // APB bundles
    //=============================

    // Master to slave, one transfer
    typedef struct packed {
        logic                   psel;
        logic                   penable;   // Low in setup, high in access
        logic                   pwrite;
        logic [`PIT_ADDR_W-1:0] paddr;
        logic [`PIT_DATA_W-1:0] pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic [`PIT_DATA_W-1:0] prdata;  // Valid in access cycle
        logic                   pready;  // Tied high, no wait states
        logic                   pslverr; // Unmapped offset
    } apb_rsp_t;

    //=============================
    // Register offsets
    //=============================

    typedef enum logic [`PIT_ADDR_W-1:0] {
        CTRL0    = 8'h00,  // bcd / mode / rw of ch0
        COUNT0   = 8'h04,  // Load or latch, read count
        CTRL1    = 8'h08,
        COUNT1   = 8'h0C,
        STATUS   = 8'h10,  // One byte per channel
        IRQ_PEND = 8'h14,  // W1C
        IRQ_EN   = 8'h18,
        PRESCALE = 8'h1C   // Tick period minus one
    } pit_reg_e;

endpackage

`default_nettype wire

//--- pit_apb_regs.sv
//=============================
// APB register block of the interval timer
// Decodes offsets into per-channel strobes, muxes readback,
// owns PRESCALE / IRQ_EN and the shared tick prescaler
//=============================
`timescale 1ns/1ps
`default_nettype none

`include "pit_macros.svh"

module pit_apb_regs
    import pit_apb_pkg::*;
    import pit_cfg_pkg::*;
(
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  apb_req_t                           i_apb,
    output apb_rsp_t                           o_apb,
    output pit_ch_req_t  [`PIT_NUM_CH-1:0]     o_ch_req,
    input  pit_ch_stat_t [`PIT_NUM_CH-1:0]     i_ch_stat,
    output logic                               o_clk_en,     // Shared count tick
    input  logic         [`PIT_NUM_CH-1:0]     i_irq_pend,
    output logic         [`PIT_NUM_CH-1:0]     o_irq_clr,    // W1C strobe
    output logic         [`PIT_NUM_CH-1:0]     o_irq_en
);

    localparam int PRESC_W = 8;
    localparam int CFG_W   = $bits(pit_cfg_t);

    // Bus phase
    logic                   w_access;
    logic                   w_wr;
    logic                   w_rd;
    pit_reg_e               w_reg;

    // Decode
    logic                   w_mapped;
    logic [`PIT_NUM_CH-1:0] w_sel_ctrl;
    logic [`PIT_NUM_CH-1:0] w_sel_count;
    logic                   w_sel_pend;
    logic                   w_sel_en;
    logic                   w_sel_presc;
    logic [`PIT_DATA_W-1:0] w_rdata;
    logic [`PIT_DATA_W-1:0] w_status;

    // Registers
    logic [PRESC_W-1:0]     r_prescale;
    logic [PRESC_W-1:0]     r_presc_cnt;
    logic                   r_clk_en;
    logic [`PIT_NUM_CH-1:0] r_irq_en;

    assign w_access = i_apb.psel & i_apb.penable;  // Access cycle only
    assign w_wr     = w_access & i_apb.pwrite;
    assign w_rd     = w_access & ~i_apb.pwrite;
    assign w_reg    = pit_reg_e'(i_apb.paddr);

    //=============================
    // Decode and readback mux
    //=============================

    always_comb begin
        w_mapped    = 1'b1;
        w_sel_ctrl  = '0;
        w_sel_count = '0;
        w_sel_pend  = 1'b0;
        w_sel_en    = 1'b0;
        w_sel_presc = 1'b0;
        w_rdata     = '0;
        case (w_reg)
            CTRL0: begin
                w_sel_ctrl[0]         = 1'b1;
                w_rdata[CFG_W-1:0]    = i_ch_stat[0].cfg;
            end
            CTRL1: begin
                w_sel_ctrl[1]         = 1'b1;
                w_rdata[CFG_W-1:0]    = i_ch_stat[1].cfg;
            end
            COUNT0: begin
                w_sel_count[0]            = 1'b1;
                w_rdata[`PIT_COUNT_W-1:0] = i_ch_stat[0].count_rb;
            end
            COUNT1: begin
                w_sel_count[1]            = 1'b1;
                w_rdata[`PIT_COUNT_W-1:0] = i_ch_stat[1].count_rb;
            end
            STATUS:   w_rdata = w_status;       // Read only, writes dropped
            IRQ_PEND: begin
                w_sel_pend                = 1'b1;
                w_rdata[`PIT_NUM_CH-1:0]  = i_irq_pend;
            end
            IRQ_EN: begin
                w_sel_en                  = 1'b1;
                w_rdata[`PIT_NUM_CH-1:0]  = r_irq_en;
            end
            PRESCALE: begin
                w_sel_presc               = 1'b1;
                w_rdata[PRESC_W-1:0]      = r_prescale;
            end
            default:  w_mapped = 1'b0;
        endcase
    end

    //=============================
    // Per-channel strobes
    //=============================

    for (genvar g = 0; g < `PIT_NUM_CH; g++) begin : g_ch
        assign o_ch_req[g].ctrl_wr  = w_wr & w_sel_ctrl[g];
        assign o_ch_req[g].cfg      = pit_cfg_t'(i_apb.pwdata[CFG_W-1:0]);
        assign o_ch_req[g].count_wr = w_wr & w_sel_count[g];
        assign o_ch_req[g].count_rd = w_rd & w_sel_count[g];
        assign o_ch_req[g].wdata    = i_apb.pwdata[`PIT_COUNT_W-1:0];
        // STATUS byte: OUT, NULL, rw, mode, bcd
        assign w_status[8*g +: 8]   = {i_ch_stat[g].out, i_ch_stat[g].null_count,
                                       i_ch_stat[g].cfg};
    end
    assign w_status[`PIT_DATA_W-1:8*`PIT_NUM_CH] = '0;

    // Writable registers
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_prescale <= '0;
            r_irq_en   <= '0;
        end else if (w_wr) begin
            if (w_sel_presc) r_prescale <= i_apb.pwdata[PRESC_W-1:0];
            if (w_sel_en)    r_irq_en   <= i_apb.pwdata[`PIT_NUM_CH-1:0];
        end
    end

    //=============================
    // Prescaler
    //=============================

    // One tick per PRESCALE+1 clocks, >= covers a shrinking PRESCALE
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_presc_cnt <= '0;
            r_clk_en    <= 1'b0;
        end else if (r_presc_cnt >= r_prescale) begin
            r_presc_cnt <= '0;
            r_clk_en    <= 1'b1;
        end else begin
            r_presc_cnt <= r_presc_cnt + 1'b1;
            r_clk_en    <= 1'b0;
        end
    end

    assign o_clk_en  = r_clk_en;
    assign o_irq_en  = r_irq_en;
    assign o_irq_clr = (w_wr && w_sel_pend) ? i_apb.pwdata[`PIT_NUM_CH-1:0] : '0;

    // Zero-wait slave
    assign o_apb.prdata  = w_rdata;
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = w_access & ~w_mapped;

endmodule

`default_nettype wire

//--- pit_cfg_pkg.sv
//=============================
// Counter-side types of the interval timer
// Control word fields, per-channel request from the
// register block and status returned by each counter
//=============================
`default_nettype none

`include "pit_macros.svh"

package pit_cfg_pkg;

    //=============================
    // Control word encodings
    //=============================

    // Read/write mode, 8254 RW1:RW0
    typedef enum logic [1:0] {
        RW_LATCH = 2'b00,  // Counter latch command
        RW_LSB   = 2'b01,
        RW_MSB   = 2'b10,
        RW_WORD  = 2'b11
    } pit_rw_e;

    // Counter mode, only MODE0 acts
    typedef enum logic [2:0] {
        MODE0 = 3'd0,  // Interrupt on terminal count
        MODE1 = 3'd1,
        MODE2 = 3'd2,
        MODE3 = 3'd3,
        MODE4 = 3'd4,
        MODE5 = 3'd5
    } pit_mode_e;

    // Field order matches CTRL bits [5:4] [3:1] [0]
    typedef struct packed {
        pit_rw_e   rw;
        pit_mode_e mode;
        logic      bcd;
    } pit_cfg_t;

    //=============================
    // Channel request / status
    //=============================

    typedef struct packed {
        logic                    ctrl_wr;   // One-cycle CTRL write
        pit_cfg_t                cfg;
        logic                    count_wr;  // Load or latch
        logic                    count_rd;  // Releases latch
        logic [`PIT_COUNT_W-1:0] wdata;
    } pit_ch_req_t;

    typedef struct packed {
        logic [`PIT_COUNT_W-1:0] count_rb;    // Readback, one cycle old
        logic                    out;
        logic                    null_count;  // No count loaded since CTRL write
        pit_cfg_t                cfg;
    } pit_ch_stat_t;

endpackage

`default_nettype wire

//--- pit_counter.sv
//=============================
// One 8254-style counter channel, mode 0 only
// Shadows its control word, loads LSB / MSB / word values,
// supports the latch command and binary or BCD countdown
//=============================
`timescale 1ns/1ps
`default_nettype none

`include "pit_macros.svh"

module pit_counter
    import pit_cfg_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  pit_ch_req_t  i_req,
    input  logic         i_gate,     // Low pauses the count
    input  logic         i_clk_en,   // Prescaler tick
    output pit_ch_stat_t o_stat
);

    localparam int CW     = `PIT_COUNT_W;
    localparam int BYTE_W = 8;
    localparam int DIGITS = CW / 4;

    pit_cfg_t        r_cfg;               // Control word shadow
    logic [CW-1:0]   r_reload_value;
    logic            r_reload_pending;
    logic [CW-1:0]   r_count;
    logic [CW-1:0]   r_latch_val;
    logic            r_latched;
    logic            r_rd_half;           // First read of latched pair done
    logic [CW-1:0]   r_count_rb;
    logic            r_null_count;
    logic            r_counting;
    logic            r_out;
    logic            w_latch_cmd;

    assign w_latch_cmd = i_req.count_wr && (r_cfg.rw == RW_LATCH);

    // Binary or BCD step down, BCD 0000 wraps to 9999
    function automatic logic [CW-1:0] dec_count(input logic [CW-1:0] cnt,
                                                input logic bcd);
        logic [CW-1:0] res;
        logic          borrow;
        int            d;
        res    = cnt;
        borrow = 1'b1;
        if (bcd) begin
            for (d = 0; d < DIGITS; d++) begin
                if (borrow) begin
                    if (res[4*d +: 4] == 4'h0) begin
                        res[4*d +: 4] = 4'h9;       // Borrow ripples up
                    end else begin
                        res[4*d +: 4] = res[4*d +: 4] - 4'h1;
                        borrow        = 1'b0;
                    end
                end
            end
        end else begin
            res = cnt - 1'b1;
        end
        return res;
    endfunction

    //=============================
    // Control word and load
    //=============================

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_cfg <= '{rw: RW_LATCH, mode: MODE0, bcd: 1'b0};
        end else if (i_req.ctrl_wr) begin
            r_cfg <= i_req.cfg;   // Mode kept for STATUS only
        end
    end

    // Pending one cycle after the strobe, count loads the cycle after
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_reload_pending <= 1'b0;
        end else begin
            r_reload_pending <= i_req.count_wr && (r_cfg.rw != RW_LATCH);
        end
    end

    always_ff @(posedge clk) begin
        if (i_req.count_wr) begin
            case (r_cfg.rw)
                RW_LSB:  r_reload_value <= {{BYTE_W{1'b0}}, i_req.wdata[BYTE_W-1:0]};
                RW_MSB:  r_reload_value <= {i_req.wdata[BYTE_W-1:0], {BYTE_W{1'b0}}};
                RW_WORD: r_reload_value <= i_req.wdata;
                default: r_reload_value <= r_reload_value;   // Latch cmd, no load
            endcase
        end
    end

    //=============================
    // Latch and readback
    //=============================

    // Latched value survives one read pair, like LSB then MSB on the 8254
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_latched <= 1'b0;
            r_rd_half <= 1'b0;
        end else if (w_latch_cmd && !r_latched) begin
            r_latched <= 1'b1;
            r_rd_half <= 1'b0;
        end else if (i_req.count_rd && r_latched) begin
            r_rd_half <= ~r_rd_half;
            if (r_rd_half) r_latched <= 1'b0;    // Second read releases
        end
    end

    always_ff @(posedge clk) begin
        if (w_latch_cmd && !r_latched) r_latch_val <= r_count;  // Repeat cmd ignored
        r_count_rb <= r_latched ? r_latch_val : r_count;       // Refreshed every cycle
    end

    //=============================
    // Mode 0 core
    //=============================

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_count      <= '0;
            r_null_count <= 1'b1;
            r_counting   <= 1'b0;
            r_out        <= 1'b0;
        end else if (i_req.ctrl_wr) begin
            r_null_count <= 1'b1;       // New control word, wait for count
            r_counting   <= 1'b0;
            r_out        <= 1'b0;
        end else if (r_reload_pending) begin
            r_count      <= r_reload_value;
            r_null_count <= 1'b0;
            r_counting   <= 1'b0;       // Arms on next gated tick
            r_out        <= 1'b0;       // OUT low on load
        end else if (r_counting) begin
            if (i_clk_en && i_gate) begin
                if (r_count == '0) begin
                    r_out      <= 1'b1;  // Terminal count
                    r_counting <= 1'b0;
                end else begin
                    r_count <= dec_count(r_count, r_cfg.bcd);
                end
            end
        end else if (!r_null_count && !r_out && i_gate && i_clk_en) begin
            r_counting <= 1'b1;
        end
    end

    assign o_stat.count_rb   = r_count_rb;
    assign o_stat.out        = r_out;
    assign o_stat.null_count = r_null_count;
    assign o_stat.cfg        = r_cfg;

endmodule

`default_nettype wire

//--- pit_irq_combine.sv
//=============================
// Interrupt combiner for the timer channels
// Rising OUT edges set sticky pending bits,
// o_irq is the registered OR of pending and enable
//=============================
`timescale 1ns/1ps
`default_nettype none

`include "pit_macros.svh"

module pit_irq_combine (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic [`PIT_NUM_CH-1:0] i_out,
    input  logic [`PIT_NUM_CH-1:0] i_clr,   // W1C from IRQ_PEND
    input  logic [`PIT_NUM_CH-1:0] i_en,
    output logic [`PIT_NUM_CH-1:0] o_pend,
    output logic                   o_irq
);

    logic [`PIT_NUM_CH-1:0] r_out_q;
    logic [`PIT_NUM_CH-1:0] r_pend;
    logic                   r_irq;
    logic [`PIT_NUM_CH-1:0] w_rise;

    assign w_rise = i_out & ~r_out_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_out_q <= '0;
            r_pend  <= '0;
            r_irq   <= 1'b0;
        end else begin
            r_out_q <= i_out;
            r_pend  <= (r_pend & ~i_clr) | w_rise;  // Set beats clear
            r_irq   <= |(r_pend & i_en);
        end
    end

    assign o_pend = r_pend;
    assign o_irq  = r_irq;

endmodule

`default_nettype wire

//--- pit_macros.svh
//=============================
// Global sizes for the two-channel interval timer
// Included by the packages and every RTL module
// Widths of APB bus, counters and channel vectors
//=============================
`ifndef PIT_MACROS_SVH
`define PIT_MACROS_SVH

//=============================
// APB bus
//=============================

// Byte address, covers 0x00..0x1C
`define PIT_ADDR_W 8

// Read and write data
`define PIT_DATA_W 32

//=============================
// Counter side
//=============================

// Down-counter width, 8254 style
`define PIT_COUNT_W 16

// Channels, sizes gate/out/irq vectors
`define PIT_NUM_CH 2

`endif

//--- pit_top.sv
//=============================
// Two-channel interval timer, APB attached
// Register block, two mode 0 counters and one
// combined interrupt line
//=============================
`timescale 1ns/1ps
`default_nettype none

`include "pit_macros.svh"

module pit_top
    import pit_apb_pkg::*;
    import pit_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  apb_req_t               i_apb,
    output apb_rsp_t               o_apb,
    input  logic [`PIT_NUM_CH-1:0] i_gate,
    output logic [`PIT_NUM_CH-1:0] o_out,
    output logic                   o_irq
);

    pit_ch_req_t  [`PIT_NUM_CH-1:0] w_ch_req;
    pit_ch_stat_t [`PIT_NUM_CH-1:0] w_ch_stat;
    logic                           w_clk_en;     // Shared tick
    logic         [`PIT_NUM_CH-1:0] w_out;
    logic         [`PIT_NUM_CH-1:0] w_irq_pend;
    logic         [`PIT_NUM_CH-1:0] w_irq_clr;
    logic         [`PIT_NUM_CH-1:0] w_irq_en;

    pit_apb_regs u_regs (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_apb      (i_apb),
        .o_apb      (o_apb),
        .o_ch_req   (w_ch_req),
        .i_ch_stat  (w_ch_stat),
        .o_clk_en   (w_clk_en),
        .i_irq_pend (w_irq_pend),
        .o_irq_clr  (w_irq_clr),
        .o_irq_en   (w_irq_en)
    );

    pit_counter u_ch0 (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_req    (w_ch_req[0]),
        .i_gate   (i_gate[0]),
        .i_clk_en (w_clk_en),
        .o_stat   (w_ch_stat[0])
    );

    pit_counter u_ch1 (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_req    (w_ch_req[1]),
        .i_gate   (i_gate[1]),
        .i_clk_en (w_clk_en),
        .o_stat   (w_ch_stat[1])
    );

    assign w_out[0] = w_ch_stat[0].out;
    assign w_out[1] = w_ch_stat[1].out;
    assign o_out    = w_out;

    pit_irq_combine u_irq (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_out   (w_out),
        .i_clr   (w_irq_clr),
        .i_en    (w_irq_en),
        .o_pend  (w_irq_pend),
        .o_irq   (o_irq)
    );

endmodule

`default_nettype wire

//--- pit_top_assert.sv
//=============================
// Protocol and interrupt checks for the timer top
// Bound into every pit_top instance
//=============================
`timescale 1ns/1ps
`default_nettype none

`include "pit_macros.svh"

module pit_top_assert
    import pit_apb_pkg::*;
(
    input logic                   clk,
    input logic                   i_rst_n,
    input apb_req_t               i_apb,
    input apb_rsp_t               i_apb_rsp,
    input logic [`PIT_NUM_CH-1:0] i_pend,
    input logic [`PIT_NUM_CH-1:0] i_en,
    input logic                   i_irq
);

    // Zero-wait slave
    a_pready: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_apb_rsp.pready)
        else $error("pready low");

    // Error response only in an access cycle
    a_slverr: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_apb_rsp.pslverr |-> (i_apb.psel && i_apb.penable))
        else $error("pslverr outside access cycle");

    // Registered irq needs an enabled pending bit one cycle back
    a_irq_src: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_irq |-> $past(|(i_pend & i_en)))
        else $error("o_irq without enabled pending bit");

endmodule

bind pit_top pit_top_assert u_assert (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_apb     (i_apb),
    .i_apb_rsp (o_apb),
    .i_pend    (w_irq_pend),
    .i_en      (w_irq_en),
    .i_irq     (o_irq)
);

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the timer regression with Verilator.
# Exit status is nonzero unless the pass line appears.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pit_top \
    -f verilog.f -o tb_pit_top \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_pit_top 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "Regression passed" \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }

//--- tb_pit_top.sv
//=============================
// Directed testbench for the two-channel interval timer
// Drives APB and gates on the falling edge, checks load
// formats, latch, BCD step, terminal count, IRQ, errors
//=============================
`timescale 1ns/1ps
`default_nettype none

`include "pit_macros.svh"

module tb_pit_top
    import pit_apb_pkg::*;
    import pit_cfg_pkg::*;
();

    localparam int          RST_CYC     = 16;
    localparam int          TIMEOUT_CYC = 20000;   // Tests need about 4000
    localparam int          POLL_MAX    = 300;     // Two prescaler periods of polls
    localparam logic [31:0] LFSR_SEED   = 32'h2775;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic                   clk;
    logic                   rst_n;
    apb_req_t               apb_req;
    apb_rsp_t               apb_rsp;
    logic [`PIT_NUM_CH-1:0] gate;
    logic [`PIT_NUM_CH-1:0] out;
    logic                   irq;
    logic [31:0]            lfsr;
    int                     err_cnt;
    int                     chk_cnt;
    int                     cyc_cnt;

    pit_top u_pit_top (
        .clk     (clk),
        .i_rst_n (rst_n),
        .i_apb   (apb_req),
        .o_apb   (apb_rsp),
        .i_gate  (gate),
        .o_out   (out),
        .o_irq   (irq)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;   // 100 ns period

    // Run limit
    always @(posedge clk) begin
        if (!rst_n) begin
            cyc_cnt <= 0;
        end else begin
            cyc_cnt <= cyc_cnt + 1;
            if (cyc_cnt >= TIMEOUT_CYC) begin
                $display("Timeout after %0d cycles, a test never finished", cyc_cnt);
                $display("Regression failed");
                $finish;
            end
        end
    end

    //=============================
    // Helpers
    //=============================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [`PIT_COUNT_W-1:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[`PIT_COUNT_W-2:0], lfsr[0]};
        end
    endtask

    task automatic chk_data(input string name, input logic [`PIT_DATA_W-1:0] act,
                            input logic [`PIT_DATA_W-1:0] exp);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERROR t=%0t %s got=%h exp=%h", $time, name, act, exp);
        end
    endtask

    task automatic chk_bit(input string name, input logic act, input logic exp);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERROR t=%0t %s got=%b exp=%b", $time, name, act, exp);
        end
    endtask

    task automatic chk_rsp(input string name, input apb_rsp_t rsp, input logic exp_err);
        chk_bit({name, " pready"}, rsp.pready, 1'b1);
        chk_bit({name, " pslverr"}, rsp.pslverr, exp_err);
    endtask

    task automatic report_fail(input string what);
        err_cnt++;
        $display("Check failed at %0t: %s", $time, what);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Setup cycle, access cycle, sample just after access drive
    task automatic apb_xfer(input logic wr, input logic [`PIT_ADDR_W-1:0] addr,
                            input logic [`PIT_DATA_W-1:0] wdata, input logic exp_err,
                            output logic [`PIT_DATA_W-1:0] rdata);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        rdata = apb_rsp.prdata;
        chk_rsp("APB", apb_rsp, exp_err);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [`PIT_ADDR_W-1:0] addr,
                             input logic [`PIT_DATA_W-1:0] data);
        logic [`PIT_DATA_W-1:0] unused_rd;
        apb_xfer(1'b1, addr, data, 1'b0, unused_rd);
    endtask

    task automatic apb_read(input logic [`PIT_ADDR_W-1:0] addr,
                            output logic [`PIT_DATA_W-1:0] data);
        apb_xfer(1'b0, addr, '0, 1'b0, data);
    endtask

    // CTRL layout: bit 0 BCD, 3:1 mode, 5:4 rw
    function automatic logic [`PIT_DATA_W-1:0] cfg_word(input pit_rw_e rw, input logic bcd);
        logic [`PIT_DATA_W-1:0] w;
        w      = '0;
        w[0]   = bcd;
        w[3:1] = MODE0;
        w[5:4] = rw;
        return w;
    endfunction

    function automatic logic [`PIT_ADDR_W-1:0] ctrl_addr(input int ch);
        return (ch == 0) ? CTRL0 : CTRL1;
    endfunction

    function automatic logic [`PIT_ADDR_W-1:0] count_addr(input int ch);
        return (ch == 0) ? COUNT0 : COUNT1;
    endfunction

    // Reload value per load format
    function automatic logic [`PIT_COUNT_W-1:0] load_image(input pit_rw_e rw,
                                                           input logic [`PIT_COUNT_W-1:0] v);
        case (rw)
            RW_LSB:  return {8'h00, v[7:0]};
            RW_MSB:  return {v[7:0], 8'h00};   // Byte goes to the high half
            default: return v;
        endcase
    endfunction

    task automatic load_count(input int ch, input pit_rw_e rw, input logic bcd,
                              input logic [`PIT_COUNT_W-1:0] val);
        apb_write(ctrl_addr(ch), cfg_word(rw, bcd));
        apb_write(count_addr(ch), `PIT_DATA_W'(val));
    endtask

    // Poll STATUS until the channel OUT bit is set
    task automatic wait_out(input int ch);
        logic [`PIT_DATA_W-1:0] st;
        int                     n;
        n  = 0;
        st = '0;
        while (!st[8*ch+7] && n < POLL_MAX) begin
            apb_read(STATUS, st);
            n++;
        end
        if (!st[8*ch+7]) report_fail($sformatf("channel %0d OUT never rose", ch));
    endtask

    //=============================
    // Tests
    //=============================

    task automatic check_load(input int ch, input pit_rw_e rw);
        logic [`PIT_COUNT_W-1:0] val;
        logic [`PIT_DATA_W-1:0]  rd;
        rand_bits(`PIT_COUNT_W, val);
        load_count(ch, rw, 1'b0, val);
        idle(2);                                  // Load plus readback refresh
        apb_read(count_addr(ch), rd);
        chk_data($sformatf("COUNT%0d %s load", ch, rw.name()), rd,
                 `PIT_DATA_W'(load_image(rw, val)));
    endtask

    task automatic test_reset_load();
        logic [`PIT_DATA_W-1:0] rd;
        apb_read(STATUS, rd);
        chk_data("STATUS after reset", rd, 32'h0000_4040);  // NULL set, OUT low
        check_load(0, RW_WORD);
        check_load(0, RW_LSB);
        check_load(0, RW_MSB);
        check_load(1, RW_WORD);
        apb_read(STATUS, rd);
        chk_bit("STATUS null ch0", rd[6], 1'b0);
        chk_bit("STATUS null ch1", rd[14], 1'b0);
    endtask

    // Latch on a held count, then reload and run, latch survives one read pair
    task automatic test_latch();
        logic [`PIT_DATA_W-1:0]  rd1;
        logic [`PIT_DATA_W-1:0]  rd2;
        logic [`PIT_DATA_W-1:0]  rd3;
        logic [`PIT_DATA_W-1:0]  rd4;
        logic [`PIT_COUNT_W-1:0] val;
        gate[0] = 1'b0;
        apb_write(PRESCALE, 32'h0);             // Tick every cycle
        load_count(0, RW_WORD, 1'b0, 16'h1234);
        idle(2);
        apb_write(CTRL0, cfg_word(RW_LATCH, 1'b0));
        apb_write(COUNT0, 32'h0);               // Latch command
        rand_bits(`PIT_COUNT_W, val);
        val[`PIT_COUNT_W-1] = 1'b1;             // Far from zero
        load_count(0, RW_WORD, 1'b0, val);
        gate[0] = 1'b1;
        idle(4);
        apb_read(COUNT0, rd1);
        apb_read(COUNT0, rd2);
        apb_read(COUNT0, rd3);
        apb_read(COUNT0, rd4);
        chk_data("COUNT0 latched read 1", rd1, 32'h1234);
        chk_data("COUNT0 latched read 2", rd2, 32'h1234);
        if (rd3 == rd2) report_fail("COUNT0 still frozen after the latched pair");
        if (!(rd4 < rd3)) report_fail("COUNT0 not decreasing after the latch released");
        gate[0] = 1'b0;
    endtask

    task automatic test_bcd(input logic bcd, input logic [`PIT_COUNT_W-1:0] exp);
        logic [`PIT_DATA_W-1:0] rd;
        int                     n;
        gate[0] = 1'b0;
        apb_write(PRESCALE, 32'hFF);            // Tick every 256 cycles
        load_count(0, RW_WORD, bcd, 16'h0010);
        idle(2);
        gate[0] = 1'b1;
        n  = 0;
        rd = 32'h10;
        while (rd == 32'h10 && n < POLL_MAX) begin
            apb_read(COUNT0, rd);
            n++;
        end
        gate[0] = 1'b0;                         // Freeze before the next tick
        if (rd == 32'h10) report_fail("COUNT0 never moved with gate high");
        idle(2);
        apb_read(COUNT0, rd);
        chk_data(bcd ? "COUNT0 BCD step" : "COUNT0 binary step", rd, `PIT_DATA_W'(exp));
    endtask

    task automatic test_terminal();
        logic [`PIT_DATA_W-1:0]  rd;
        logic [`PIT_COUNT_W-1:0] val0;
        logic [`PIT_COUNT_W-1:0] val1;
        gate = '0;
        apb_write(PRESCALE, 32'h0);
        rand_bits(`PIT_COUNT_W, val1);
        load_count(1, RW_WORD, 1'b0, val1);     // Stays gated off
        rand_bits(3, val0);
        load_count(0, RW_WORD, 1'b0, val0 + 16'd4);
        gate[0] = 1'b1;
        wait_out(0);
        chk_bit("o_out[0]", out[0], 1'b1);
        chk_bit("o_out[1]", out[1], 1'b0);
        apb_read(COUNT0, rd);
        chk_data("COUNT0 at terminal count", rd, 32'h0);
        apb_read(COUNT1, rd);
        chk_data("COUNT1 gated off", rd, `PIT_DATA_W'(val1));
        apb_read(STATUS, rd);
        chk_bit("STATUS OUT ch1", rd[15], 1'b0);
    endtask

    task automatic test_irq();
        logic [`PIT_DATA_W-1:0] rd;
        gate = '0;
        apb_write(IRQ_PEND, 32'h3);             // Drop pending left by earlier TC
        apb_write(IRQ_EN, 32'h1);               // Channel 0 only
        load_count(1, RW_WORD, 1'b0, 16'd6);
        gate[1] = 1'b1;
        wait_out(1);
        idle(3);                                // Pending, then registered irq
        apb_read(IRQ_PEND, rd);
        chk_data("IRQ_PEND after ch1 TC", rd, 32'h2);
        chk_bit("o_irq masked", irq, 1'b0);
        load_count(0, RW_WORD, 1'b0, 16'd6);
        gate[0] = 1'b1;
        wait_out(0);
        idle(3);
        chk_bit("o_irq", irq, 1'b1);
        apb_read(IRQ_PEND, rd);
        chk_data("IRQ_PEND both", rd, 32'h3);
        apb_write(IRQ_PEND, 32'h1);             // W1C bit 0
        idle(3);
        chk_bit("o_irq after clear", irq, 1'b0);
        apb_read(IRQ_PEND, rd);
        chk_data("IRQ_PEND after clear", rd, 32'h2);
    endtask

    task automatic test_unmapped();
        logic [`PIT_DATA_W-1:0] rd;
        apb_xfer(1'b1, 8'h20, 32'hFFFF_FFFF, 1'b1, rd);
        apb_xfer(1'b1, 8'h1A, 32'hFFFF_FFFF, 1'b1, rd);   // Misaligned
        apb_xfer(1'b0, 8'h24, 32'h0, 1'b1, rd);
        apb_read(IRQ_EN, rd);
        chk_data("IRQ_EN after unmapped", rd, 32'h1);
        apb_read(PRESCALE, rd);
        chk_data("PRESCALE after unmapped", rd, 32'h0);
        apb_read(CTRL0, rd);
        chk_data("CTRL0 after unmapped", rd, cfg_word(RW_WORD, 1'b0));
    endtask

    //=============================
    // Sequence
    //=============================

    initial begin
        apb_req = '0;
        gate    = '0;
        rst_n   = 1'b0;
        lfsr    = LFSR_SEED;
        err_cnt = 0;
        chk_cnt = 0;
        repeat (RST_CYC) @(negedge clk);
        rst_n = 1'b1;
        idle(2);
        test_reset_load();
        test_latch();
        test_bcd(1'b1, 16'h0009);   // 10 BCD minus one
        test_bcd(1'b0, 16'h000F);   // 0x10 binary minus one
        test_terminal();
        test_irq();
        test_unmapped();
        $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
pit_apb_pkg.sv
pit_cfg_pkg.sv
pit_apb_regs.sv
pit_counter.sv
pit_irq_combine.sv
pit_top.sv
pit_top_assert.sv
tb_pit_top.sv
